// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_usb_host_ctrl
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
source/usb_pkg.sv
source/usb_pkt_if.sv
source/ctrl_xfer_fsm.sv
source/response_timer.sv
source/packet_encoder.sv
source/packet_decoder.sv
source/usb_host_ctrl_top.sv
sim/usb_device_model.sv
sim/tb_usb_host_ctrl.sv

// ==== sim/tb_usb_host_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_usb_host_ctrl;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_TESTS = 6;
  localparam int TEST_CYCLES = (usb_pkg::MAX_RETRIES + 1) * 3 * (usb_pkg::TIMEOUT_CYCLES + 20);
  localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES;
  localparam logic [31:0] SEED = 32'h6b834fd6;

  logic clock;
  logic rst_n;
  logic start;
  usb_pkg::dev_addr_t new_addr;
  logic tx_valid;
  logic tx_ready;
  logic tx_last;
  usb_pkg::byte_t tx_data;
  logic rx_valid;
  logic rx_ready;
  logic rx_last;
  usb_pkg::byte_t rx_data;
  logic done;
  logic error;
  logic busy;
  usb_pkg::dev_addr_t addr;
  logic crc_err;

  logic model_clear;
  logic [127:0] test_name;
  logic [3:0] nak_count;
  logic silent;
  logic corrupt;
  int setup_cnt;
  int in_cnt;
  int ack_cnt;
  int model_errs;
  usb_pkg::byte_t last_pid;

  logic rand_ready;
  logic [31:0] addr_state;
  logic [31:0] ready_state;
  int done_cnt;
  int error_cnt;
  int crc_err_cnt;
  int assert_errs;
  int test_errors;
  int total_errors;
  int tests_passed;
  int tests_failed;
  usb_pkg::dev_addr_t addr_a;
  usb_pkg::dev_addr_t prev_addr;

  usb_host_ctrl_top DUT (
    .clock      (clock),
    .rst_n_i    (rst_n),
    .start_i    (start),
    .new_addr_i (new_addr),
    .tx_valid_o (tx_valid),
    .tx_ready_i (tx_ready),
    .tx_last_o  (tx_last),
    .tx_data_o  (tx_data),
    .rx_valid_i (rx_valid),
    .rx_ready_o (rx_ready),
    .rx_last_i  (rx_last),
    .rx_data_i  (rx_data),
    .done_o     (done),
    .error_o    (error),
    .busy_o     (busy),
    .addr_o     (addr),
    .crc_err_o  (crc_err)
  );

  usb_device_model u_device (
    .clock       (clock),
    .rst_n_i     (rst_n),
    .clear_i     (model_clear),
    .test_name_i (test_name),
    .exp_addr_i  (new_addr),
    .nak_count_i (nak_count),
    .silent_i    (silent),
    .corrupt_i   (corrupt),
    .tx_valid_i  (tx_valid),
    .tx_ready_i  (tx_ready),
    .tx_last_i   (tx_last),
    .tx_data_i   (tx_data),
    .rx_valid_o  (rx_valid),
    .rx_ready_i  (rx_ready),
    .rx_last_o   (rx_last),
    .rx_data_o   (rx_data),
    .setup_cnt_o (setup_cnt),
    .in_cnt_o    (in_cnt),
    .ack_cnt_o   (ack_cnt),
    .err_cnt_o   (model_errs),
    .last_pid_o  (last_pid)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run is stopped", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  // Random back-pressure on the transmit stream when enabled
  always @(posedge clock) begin
    if (!rst_n || !rand_ready) begin
      tx_ready <= 1'b1;
    end else begin
      ready_state = lcg_next(ready_state);
      tx_ready <= ready_state[15];
    end
  end

  always @(negedge clock) begin
    if (done) done_cnt++;
    if (error) error_cnt++;
    if (crc_err) crc_err_cnt++;
  end

  a_done_pulse: assert property (@(posedge clock) disable iff (!rst_n) done |=> !done)
    else begin
      $display("done_o stayed high for more than one cycle");
      assert_errs++;
    end

  a_error_pulse: assert property (@(posedge clock) disable iff (!rst_n) error |=> !error)
    else begin
      $display("error_o stayed high for more than one cycle");
      assert_errs++;
    end

  a_end_exclusive: assert property (@(posedge clock) disable iff (!rst_n) !(done && error))
    else begin
      $display("done_o and error_o were high in the same cycle");
      assert_errs++;
    end

  a_tx_hold: assert property (@(posedge clock) disable iff (!rst_n)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
    else begin
      $display("transmit byte changed or was dropped while tx_ready_i was low");
      assert_errs++;
    end

  task automatic next_addr(output usb_pkg::dev_addr_t a);
    addr_state = lcg_next(addr_state);
    a = addr_state[22:16];
    if (a == '0) a = 7'h01;
  endtask

  task automatic check_value(input string what, input int exp_v, input int act_v);
    assert (exp_v == act_v) else begin
      $display("Mismatch %0s %0s: expected %0h actual %0h", test_name, what, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic begin_test(input logic [127:0] name, input logic [3:0] naks,
                            input logic quiet, input logic bad_crc);
    @(posedge clock);
    test_name   <= name;
    nak_count   <= naks;
    silent      <= quiet;
    corrupt     <= bad_crc;
    model_clear <= 1'b1;
    done_cnt    = 0;
    error_cnt   = 0;
    crc_err_cnt = 0;
    test_errors = 0;
    @(posedge clock);
    model_clear <= 1'b0;
  endtask

  // Start one transfer and wait for its end pulse
  task automatic run_xfer(input usb_pkg::dev_addr_t a);
    int cycles;
    @(posedge clock);
    new_addr <= a;
    start    <= 1'b1;
    @(posedge clock);
    start <= 1'b0;
    cycles = 0;
    @(negedge clock);
    check_value("busy_o during transfer", 1, int'(busy));
    while (!done && !error && cycles < TEST_CYCLES) begin
      @(negedge clock);
      cycles++;
    end
    if (!done && !error) begin
      $display("%0s: transfer did not end within %0d cycles", test_name, TEST_CYCLES);
      test_errors++;
    end
    repeat (4) @(negedge clock);
    check_value("busy_o after transfer", 0, int'(busy));
  endtask

  task automatic end_test();
    test_errors += model_errs + assert_errs;
    assert_errs = 0;
    if (test_errors == 0) begin
      $display("test %0s: passed", test_name);
      tests_passed++;
    end else begin
      $display("test %0s: failed with %0d errors", test_name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
  endtask

  task automatic check_normal_end(input usb_pkg::dev_addr_t a);
    check_value("done pulses", 1, done_cnt);
    check_value("error pulses", 0, error_cnt);
    check_value("addr_o", int'(a), int'(addr));
    check_value("final host packet", 8'hD2, int'(last_pid));
    check_value("host ACKs", 1, ack_cnt);
  endtask

  initial begin
    rst_n        = 1'b0;
    start        = 1'b0;
    new_addr     = '0;
    tx_ready     = 1'b1;
    model_clear  = 1'b0;
    test_name    = "none";
    nak_count    = '0;
    silent       = 1'b0;
    corrupt      = 1'b0;
    rand_ready   = 1'b0;
    addr_state   = SEED;
    ready_state  = lcg_next(SEED);
    assert_errs  = 0;
    total_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);

    // Idle outputs after reset, then the SETUP and DATA0 bytes
    begin_test("setup_bytes", 4'd0, 1'b0, 1'b0);
    check_value("tx_valid_o after reset", 0, int'(tx_valid));
    check_value("done_o after reset", 0, int'(done));
    check_value("error_o after reset", 0, int'(error));
    check_value("busy_o after reset", 0, int'(busy));
    check_value("crc_err_o after reset", 0, int'(crc_err));
    check_value("addr_o after reset", 0, int'(addr));
    next_addr(addr_a);
    run_xfer(addr_a);
    check_value("SETUP tokens", 1, setup_cnt);
    check_value("done pulses", 1, done_cnt);
    end_test();

    begin_test("normal_done", 4'd0, 1'b0, 1'b0);
    next_addr(addr_a);
    run_xfer(addr_a);
    check_normal_end(addr_a);
    check_value("IN tokens", 1, in_cnt);
    end_test();

    begin_test("nak_retry", 4'(usb_pkg::MAX_RETRIES), 1'b0, 1'b0);
    next_addr(addr_a);
    run_xfer(addr_a);
    check_normal_end(addr_a);
    check_value("IN tokens", usb_pkg::MAX_RETRIES + 1, in_cnt);
    end_test();

    begin_test("silent_device", 4'd0, 1'b1, 1'b0);
    prev_addr = addr;
    next_addr(addr_a);
    // A new address that differs from the latched one
    if (addr_a == prev_addr) addr_a = addr_a ^ 7'h40;
    run_xfer(addr_a);
    check_value("error pulses", 1, error_cnt);
    check_value("done pulses", 0, done_cnt);
    check_value("SETUP tokens", usb_pkg::MAX_RETRIES + 1, setup_cnt);
    check_value("IN tokens", 0, in_cnt);
    check_value("addr_o", int'(prev_addr), int'(addr));
    end_test();

    begin_test("bad_crc", 4'd0, 1'b0, 1'b1);
    next_addr(addr_a);
    run_xfer(addr_a);
    check_normal_end(addr_a);
    check_value("crc_err_o pulses", 1, crc_err_cnt);
    check_value("IN tokens", 2, in_cnt);
    end_test();

    rand_ready = 1'b1;
    begin_test("backpressure", 4'd0, 1'b0, 1'b0);
    next_addr(addr_a);
    run_xfer(addr_a);
    check_normal_end(addr_a);
    check_value("SETUP tokens", 1, setup_cnt);
    check_value("IN tokens", 1, in_cnt);
    end_test();
    rand_ready = 1'b0;

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/usb_device_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_device_model (
  input  logic               clock,
  input  logic               rst_n_i,
  input  logic               clear_i,
  input  logic [127:0]       test_name_i,
  input  usb_pkg::dev_addr_t exp_addr_i,
  input  logic [3:0]         nak_count_i,
  input  logic               silent_i,
  input  logic               corrupt_i,
  input  logic               tx_valid_i,
  input  logic               tx_ready_i,
  input  logic               tx_last_i,
  input  usb_pkg::byte_t     tx_data_i,
  output logic               rx_valid_o,
  input  logic               rx_ready_i,
  output logic               rx_last_o,
  output usb_pkg::byte_t     rx_data_o,
  output int                 setup_cnt_o,
  output int                 in_cnt_o,
  output int                 ack_cnt_o,
  output int                 err_cnt_o,
  output usb_pkg::byte_t     last_pid_o
);

  usb_pkg::byte_t pkt[$];
  // Response bytes as {last, data}
  logic [8:0] rsp_q[$];
  logic [8:0] entry;
  int naks_sent;
  logic corrupt_done;

  initial begin
    rx_valid_o = 1'b0;
    rx_last_o  = 1'b0;
    rx_data_o  = '0;
  end

  // SET_ADDRESS request, bytes 0 to 7
  function automatic usb_pkg::byte_t request_byte(input usb_pkg::dev_addr_t a, input int idx);
    case (idx)
      1:       return 8'h05;
      2:       return {1'b0, a};
      default: return 8'h00;
    endcase
  endfunction

  task automatic expect_byte(input string kind, input int idx, input usb_pkg::byte_t exp_b,
                             input usb_pkg::byte_t act_b);
    assert (exp_b == act_b) else begin
      $display("Mismatch %0s: %0s byte %0d expected %02h actual %02h",
               test_name_i, kind, idx, exp_b, act_b);
      err_cnt_o++;
    end
  endtask

  task automatic expect_len(input string kind, input int exp_n);
    assert (pkt.size() == exp_n) else begin
      $display("Mismatch %0s: %0s length expected %0d actual %0d",
               test_name_i, kind, exp_n, pkt.size());
      err_cnt_o++;
    end
  endtask

  // Tokens always target address 0, endpoint 0
  task automatic check_token(input string kind);
    usb_pkg::crc5_t c;
    c = usb_pkg::crc5(11'h000);
    expect_len(kind, 3);
    if (pkt.size() == 3) begin
      expect_byte(kind, 1, 8'h00, pkt[1]);
      expect_byte(kind, 2, {c, 3'b000}, pkt[2]);
    end
  endtask

  task automatic check_data0();
    usb_pkg::crc16_t crc;
    usb_pkg::byte_t b;
    crc = usb_pkg::CRC16_INIT;
    expect_len("DATA0", 11);
    if (pkt.size() == 11) begin
      for (int i = 0; i < 8; i++) begin
        b = request_byte(exp_addr_i, i);
        expect_byte("DATA0", i + 1, b, pkt[i + 1]);
        crc = usb_pkg::crc16(crc, b);
      end
      expect_byte("DATA0", 9, ~crc[7:0], pkt[9]);
      expect_byte("DATA0", 10, ~crc[15:8], pkt[10]);
    end
  endtask

  // NAKs first, then a zero-length DATA1, the first one optionally damaged
  task automatic answer_in();
    usb_pkg::crc16_t crc;
    crc = ~usb_pkg::CRC16_INIT;
    if (naks_sent < int'(nak_count_i)) begin
      rsp_q.push_back({1'b1, 8'h5A});
      naks_sent++;
    end else begin
      rsp_q.push_back({1'b0, 8'h4B});
      if (corrupt_i && !corrupt_done) begin
        rsp_q.push_back({1'b0, crc[7:0] ^ 8'h01});
        corrupt_done = 1'b1;
      end else begin
        rsp_q.push_back({1'b0, crc[7:0]});
      end
      rsp_q.push_back({1'b1, crc[15:8]});
    end
  endtask

  task automatic handle_packet();
    last_pid_o = pkt[0];
    case (pkt[0])
      8'h2D: begin
        check_token("SETUP token");
        setup_cnt_o++;
      end
      8'h69: begin
        check_token("IN token");
        in_cnt_o++;
        if (!silent_i) answer_in();
      end
      8'hC3: begin
        check_data0();
        if (!silent_i) rsp_q.push_back({1'b1, 8'hD2});
      end
      8'hD2: ack_cnt_o++;
      default: begin
        $display("%0s: device saw a host packet with unknown PID byte %02h",
                 test_name_i, pkt[0]);
        err_cnt_o++;
      end
    endcase
  endtask

  always @(posedge clock) begin
    if (!rst_n_i) begin
      rx_valid_o <= 1'b0;
      rx_last_o  <= 1'b0;
      rx_data_o  <= '0;
      pkt.delete();
      rsp_q.delete();
    end
    if (!rst_n_i || clear_i) begin
      setup_cnt_o  = 0;
      in_cnt_o     = 0;
      ack_cnt_o    = 0;
      err_cnt_o    = 0;
      last_pid_o   = '0;
      naks_sent    = 0;
      corrupt_done = 1'b0;
    end
    if (rst_n_i) begin
      if (tx_valid_i && tx_ready_i) begin
        pkt.push_back(tx_data_i);
        if (tx_last_i) begin
          handle_packet();
          pkt.delete();
        end
      end
      // Present the next response byte once the current one is taken
      if (!rx_valid_o || rx_ready_i) begin
        if (rsp_q.size() > 0) begin
          entry = rsp_q.pop_front();
          rx_valid_o <= 1'b1;
          rx_last_o  <= entry[8];
          rx_data_o  <= entry[7:0];
        end else begin
          rx_valid_o <= 1'b0;
          rx_last_o  <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/ctrl_xfer_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_xfer_fsm (
  input  logic                 clock,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  usb_pkg::dev_addr_t   new_addr_i,
  usb_tx_cmd_if.master         tx,
  usb_rx_evt_if.slave          rx,
  output logic                 timer_start_o,
  output logic                 timer_stop_o,
  input  logic                 timer_expired_i,
  output logic                 done_o,
  output logic                 error_o,
  output logic                 busy_o,
  output usb_pkg::dev_addr_t   addr_o
);

  usb_pkg::xfer_state_t state_q;
  usb_pkg::xfer_state_t state_d;
  logic [usb_pkg::RETRY_W-1:0] retry_q;
  usb_pkg::dev_addr_t new_addr_q;
  logic wait_state;
  logic rx_event;
  logic stage_ok;
  logic stage_bad;
  logic retry_left;

  assign wait_state = (state_q == usb_pkg::WAIT_ACK) || (state_q == usb_pkg::WAIT_DATA);
  assign rx_event = rx.hsk_recv || rx.data_recv || rx.crc_bad;
  assign retry_left = (retry_q != usb_pkg::RETRY_LAST);

  // Success condition of each response wait
  always_comb begin
    case (state_q)
      usb_pkg::WAIT_ACK:
        stage_ok = rx.hsk_recv && (rx.hsk_pid == usb_pkg::PID_ACK);
      usb_pkg::WAIT_DATA:
        stage_ok = rx.data_recv && (rx.data_pid == usb_pkg::PID_DATA1) && (rx.data_len == '0);
      default:
        stage_ok = 1'b0;
    endcase
  end

  // Anything else that ends a wait (NAK, bad packet, timeout) counts against the stage
  assign stage_bad = wait_state && !stage_ok && (rx_event || timer_expired_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      usb_pkg::IDLE:       if (start_i) state_d = usb_pkg::SETUP_TOK;
      usb_pkg::SETUP_TOK:  if (tx.done) state_d = usb_pkg::SETUP_DATA;
      usb_pkg::SETUP_DATA: if (tx.done) state_d = usb_pkg::WAIT_ACK;
      usb_pkg::WAIT_ACK: begin
        if (stage_ok) state_d = usb_pkg::IN_TOK;
        else if (stage_bad) state_d = retry_left ? usb_pkg::SETUP_TOK : usb_pkg::FAIL;
      end
      usb_pkg::IN_TOK:     if (tx.done) state_d = usb_pkg::WAIT_DATA;
      usb_pkg::WAIT_DATA: begin
        if (stage_ok) state_d = usb_pkg::SEND_ACK;
        else if (stage_bad) state_d = retry_left ? usb_pkg::IN_TOK : usb_pkg::FAIL;
      end
      usb_pkg::SEND_ACK:   if (tx.done) state_d = usb_pkg::DONE;
      default:             state_d = usb_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q <= usb_pkg::IDLE;
      retry_q <= '0;
      addr_o  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == usb_pkg::IDLE || stage_ok) begin
        retry_q <= '0;
      end else if (stage_bad) begin
        retry_q <= retry_q + 1'b1;
      end
      // Address becomes visible together with done_o
      if (state_q == usb_pkg::SEND_ACK && tx.done) begin
        addr_o <= new_addr_q;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == usb_pkg::IDLE && start_i) begin
      new_addr_q <= new_addr_i;
    end
  end

  // Packet request per sending state
  always_comb begin
    tx.send = 1'b1;
    tx.pid  = usb_pkg::PID_ACK;
    case (state_q)
      usb_pkg::SETUP_TOK:  tx.pid = usb_pkg::PID_SETUP;
      usb_pkg::SETUP_DATA: tx.pid = usb_pkg::PID_DATA0;
      usb_pkg::IN_TOK:     tx.pid = usb_pkg::PID_IN;
      usb_pkg::SEND_ACK:   tx.pid = usb_pkg::PID_ACK;
      default:             tx.send = 1'b0;
    endcase
  end

  // Both tokens go to the default address on endpoint 0
  assign tx.tok_addr  = '0;
  assign tx.tok_endp  = '0;
  assign tx.req_value = new_addr_q;

  assign timer_start_o = tx.done &&
                         (state_q == usb_pkg::SETUP_DATA || state_q == usb_pkg::IN_TOK);
  assign timer_stop_o  = wait_state && rx_event;

  assign done_o  = (state_q == usb_pkg::DONE);
  assign error_o = (state_q == usb_pkg::FAIL);
  assign busy_o  = (state_q != usb_pkg::IDLE);

  // A request stays up until the encoder has finished the packet
  a_send_held: assert property (@(posedge clock) disable iff (!rst_n_i)
    tx.send && !tx.done |=> tx.send);

  a_end_exclusive: assert property (@(posedge clock) disable iff (!rst_n_i)
    !(done_o && error_o));

endmodule

`default_nettype wire

// ==== source/packet_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_decoder (
  input  logic           clock,
  input  logic           rst_n_i,
  input  logic           rx_valid_i,
  output logic           rx_ready_o,
  input  logic           rx_last_i,
  input  usb_pkg::byte_t rx_data_i,
  usb_rx_evt_if.master   evt,
  output logic           crc_err_o
);

  logic ready_q;
  logic first_q;
  logic accept;
  logic pid_good_now;
  logic pid_ok_q;
  usb_pkg::pid_t pid_q;
  logic [3:0] cnt_q;
  usb_pkg::byte_t b0_q;
  usb_pkg::byte_t b1_q;
  usb_pkg::crc16_t crc_q;
  usb_pkg::crc16_t crc_next;
  logic crc_match;
  logic hsk_recv_q;
  logic data_recv_q;
  logic crc_bad_q;

  assign rx_ready_o = ready_q;
  assign accept = rx_valid_i && ready_q;
  assign pid_good_now = (rx_data_i[7:4] == ~rx_data_i[3:0]);

  // The last two bytes are held back, so the CRC runs two bytes behind the stream
  assign crc_next  = (cnt_q >= 4'd2) ? usb_pkg::crc16(crc_q, b1_q) : crc_q;
  assign crc_match = ({rx_data_i, b0_q} == ~crc_next);

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      ready_q     <= 1'b0;
      first_q     <= 1'b1;
      hsk_recv_q  <= 1'b0;
      data_recv_q <= 1'b0;
      crc_bad_q   <= 1'b0;
    end else begin
      ready_q     <= 1'b1;
      hsk_recv_q  <= 1'b0;
      data_recv_q <= 1'b0;
      crc_bad_q   <= 1'b0;
      if (accept) begin
        first_q <= rx_last_i;
        if (rx_last_i && first_q) begin
          // Single byte packet must be a valid handshake
          if (pid_good_now && rx_data_i[1:0] == usb_pkg::PID_CLASS_HSK) begin
            hsk_recv_q <= 1'b1;
          end else begin
            crc_bad_q <= 1'b1;
          end
        end else if (rx_last_i) begin
          if (!pid_ok_q) begin
            crc_bad_q <= 1'b1;
          end else if (pid_q[1:0] == usb_pkg::PID_CLASS_DATA) begin
            if (cnt_q >= 4'd1 && cnt_q <= 4'd9 && crc_match) begin
              data_recv_q <= 1'b1;
            end else begin
              crc_bad_q <= 1'b1;
            end
          end
          // Tokens from the device side are dropped
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      if (first_q) begin
        pid_q    <= rx_data_i[3:0];
        pid_ok_q <= pid_good_now;
        cnt_q    <= '0;
        crc_q    <= usb_pkg::CRC16_INIT;
        evt.hsk_pid <= rx_data_i[3:0];
      end else begin
        b0_q  <= rx_data_i;
        b1_q  <= b0_q;
        crc_q <= crc_next;
        if (cnt_q != 4'hF) begin
          cnt_q <= cnt_q + 4'd1;
        end
        evt.data_pid <= pid_q;
        evt.data_len <= usb_pkg::len_t'(cnt_q - 4'd1);  // bytes before the CRC pair
      end
    end
  end

  assign evt.hsk_recv  = hsk_recv_q;
  assign evt.data_recv = data_recv_q;
  assign evt.crc_bad   = crc_bad_q;
  assign crc_err_o     = crc_bad_q;

endmodule

`default_nettype wire

// ==== source/packet_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_encoder (
  input  logic           clock,
  input  logic           rst_n_i,
  usb_tx_cmd_if.slave    cmd,
  output logic           tx_valid_o,
  input  logic           tx_ready_i,
  output logic           tx_last_o,
  output usb_pkg::byte_t tx_data_o
);

  logic sending_q;
  logic done_q;
  logic capture;
  logic accept;
  logic [3:0] idx_q;
  logic [3:0] last_idx;
  usb_pkg::pid_t pid_q;
  usb_pkg::dev_addr_t addr_q;
  usb_pkg::endp_t endp_q;
  usb_pkg::dev_addr_t value_q;
  usb_pkg::crc16_t crc_q;
  usb_pkg::crc5_t tok_crc;
  logic is_data;

  // A new request is taken only from idle, never in the done cycle
  assign capture = cmd.send && !sending_q && !done_q;
  assign accept  = tx_valid_o && tx_ready_i;
  assign is_data = (pid_q[1:0] == usb_pkg::PID_CLASS_DATA);
  assign tok_crc = usb_pkg::crc5({endp_q, addr_q});

  // PID only, token with two more bytes, or DATA0 with request and CRC
  always_comb begin
    case (pid_q[1:0])
      usb_pkg::PID_CLASS_TOKEN: last_idx = 4'd2;
      usb_pkg::PID_CLASS_DATA:  last_idx = 4'd10;
      default:                  last_idx = 4'd0;
    endcase
  end

  always_comb begin
    case (idx_q)
      4'd0:  tx_data_o = {~pid_q, pid_q};
      4'd1:  tx_data_o = is_data ? usb_pkg::REQ_TYPE_HOST_DEV : {endp_q[0], addr_q};
      4'd2:  tx_data_o = is_data ? usb_pkg::REQ_SET_ADDRESS : {tok_crc, endp_q[3:1]};
      // wValue low byte carries the new address
      4'd3:  tx_data_o = {1'b0, value_q};
      4'd9:  tx_data_o = ~crc_q[7:0];
      4'd10: tx_data_o = ~crc_q[15:8];
      // wValue high, wIndex and wLength are all zero
      default: tx_data_o = 8'h00;
    endcase
  end

  assign tx_valid_o = sending_q;
  assign tx_last_o  = sending_q && (idx_q == last_idx);
  assign cmd.done   = done_q;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      sending_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (capture) begin
        sending_q <= 1'b1;
      end else if (accept && tx_last_o) begin
        sending_q <= 1'b0;
        done_q    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      pid_q   <= cmd.pid;
      addr_q  <= cmd.tok_addr;
      endp_q  <= cmd.tok_endp;
      value_q <= cmd.req_value;
      idx_q   <= '0;
      crc_q   <= usb_pkg::CRC16_INIT;
    end else if (accept) begin
      idx_q <= idx_q + 4'd1;
      // CRC covers the eight request bytes only
      if (is_data && idx_q >= 4'd1 && idx_q <= 4'd8) begin
        crc_q <= usb_pkg::crc16(crc_q, tx_data_o);
      end
    end
  end

  a_hold_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o) && $stable(tx_last_o));

endmodule

`default_nettype wire

// ==== source/response_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module response_timer (
  input  logic clock,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);

  logic [usb_pkg::TIMER_W-1:0] cnt_q;
  logic running_q;

  // Fires TIMEOUT_CYCLES cycles after the start pulse
  assign expired_o = running_q && (cnt_q == '0);

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
    end else if (start_i) begin
      running_q <= 1'b1;
    end else if (stop_i || expired_o) begin
      running_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start_i) begin
      cnt_q <= usb_pkg::TIMER_LOAD;
    end else if (running_q && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  a_single_expiry: assert property (@(posedge clock) disable iff (!rst_n_i)
    expired_o |=> !expired_o);

endmodule

`default_nettype wire

// ==== source/usb_host_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_host_ctrl_top (
  input  logic               clock,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  usb_pkg::dev_addr_t new_addr_i,
  output logic               tx_valid_o,
  input  logic               tx_ready_i,
  output logic               tx_last_o,
  output usb_pkg::byte_t     tx_data_o,
  input  logic               rx_valid_i,
  output logic               rx_ready_o,
  input  logic               rx_last_i,
  input  usb_pkg::byte_t     rx_data_i,
  output logic               done_o,
  output logic               error_o,
  output logic               busy_o,
  output usb_pkg::dev_addr_t addr_o,
  output logic               crc_err_o
);

  logic timer_start;
  logic timer_stop;
  logic timer_expired;

  usb_tx_cmd_if tx_cmd ();
  usb_rx_evt_if rx_evt ();

  ctrl_xfer_fsm u_fsm (
    .clock           (clock),
    .rst_n_i         (rst_n_i),
    .start_i         (start_i),
    .new_addr_i      (new_addr_i),
    .tx              (tx_cmd),
    .rx              (rx_evt),
    .timer_start_o   (timer_start),
    .timer_stop_o    (timer_stop),
    .timer_expired_i (timer_expired),
    .done_o          (done_o),
    .error_o         (error_o),
    .busy_o          (busy_o),
    .addr_o          (addr_o)
  );

  response_timer u_timer (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .start_i   (timer_start),
    .stop_i    (timer_stop),
    .expired_o (timer_expired)
  );

  packet_encoder u_enc (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .cmd        (tx_cmd),
    .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i),
    .tx_last_o  (tx_last_o),
    .tx_data_o  (tx_data_o)
  );

  packet_decoder u_dec (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .rx_valid_i (rx_valid_i),
    .rx_ready_o (rx_ready_o),
    .rx_last_i  (rx_last_i),
    .rx_data_i  (rx_data_i),
    .evt        (rx_evt),
    .crc_err_o  (crc_err_o)
  );

endmodule

`default_nettype wire

// ==== source/usb_pkg.sv ====
`default_nettype none

package usb_pkg;

  typedef logic [3:0] pid_t;
  typedef logic [6:0] dev_addr_t;
  typedef logic [3:0] endp_t;
  typedef logic [7:0] byte_t;
  typedef logic [4:0] crc5_t;
  typedef logic [15:0] crc16_t;
  typedef logic [3:0] len_t;

  // PID values as the low nibble of the wire byte {~pid, pid}
  localparam pid_t PID_OUT   = 4'b0001;
  localparam pid_t PID_IN    = 4'b1001;
  localparam pid_t PID_SETUP = 4'b1101;
  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;
  localparam pid_t PID_ACK   = 4'b0010;
  localparam pid_t PID_NAK   = 4'b1010;

  // Packet class lives in the two low PID bits
  localparam logic [1:0] PID_CLASS_TOKEN = 2'b01;
  localparam logic [1:0] PID_CLASS_DATA  = 2'b11;
  localparam logic [1:0] PID_CLASS_HSK   = 2'b10;

  // Standard request fields for SET_ADDRESS
  localparam byte_t REQ_TYPE_HOST_DEV = 8'h00;
  localparam byte_t REQ_SET_ADDRESS   = 8'h05;

  localparam int TIMEOUT_CYCLES = 64;
  localparam int MAX_RETRIES = 3;
  localparam int TIMER_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam int RETRY_W = $clog2(MAX_RETRIES + 1);
  localparam logic [TIMER_W-1:0] TIMER_LOAD = TIMER_W'(TIMEOUT_CYCLES - 1);
  localparam logic [RETRY_W-1:0] RETRY_LAST = RETRY_W'(MAX_RETRIES);
  localparam crc16_t CRC16_INIT = 16'hFFFF;

  typedef enum logic [3:0] {
    IDLE,
    SETUP_TOK,
    SETUP_DATA,
    WAIT_ACK,
    IN_TOK,
    WAIT_DATA,
    SEND_ACK,
    DONE,
    FAIL
  } xfer_state_t;

  // Token CRC over {endp, addr}, LSB first; result is the field as packed in the token
  function automatic crc5_t crc5(input logic [10:0] d);
    logic [4:0] c;
    c = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      c = (c[4] ^ d[i]) ? ({c[3:0], 1'b0} ^ 5'h05) : {c[3:0], 1'b0};
    end
    return ~{c[0], c[1], c[2], c[3], c[4]};
  endfunction

  // One byte step of the reflected data CRC; the packet carries the inverse, low byte first
  function automatic crc16_t crc16(input crc16_t c, input byte_t d);
    crc16_t r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      r = (r[0] ^ d[i]) ? ((r >> 1) ^ 16'hA001) : (r >> 1);
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== source/usb_pkt_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Packet requests from the sequencer to the encoder
interface usb_tx_cmd_if;
  logic                 send;
  usb_pkg::pid_t        pid;
  usb_pkg::dev_addr_t   tok_addr;
  usb_pkg::endp_t       tok_endp;
  usb_pkg::dev_addr_t   req_value;
  logic                 done;

  modport master (output send, pid, tok_addr, tok_endp, req_value, input done);
  modport slave (input send, pid, tok_addr, tok_endp, req_value, output done);
endinterface

// Received packet events from the decoder to the sequencer
interface usb_rx_evt_if;
  logic             hsk_recv;
  usb_pkg::pid_t    hsk_pid;
  logic             data_recv;
  usb_pkg::pid_t    data_pid;
  usb_pkg::len_t    data_len;
  logic             crc_bad;

  modport master (output hsk_recv, hsk_pid, data_recv, data_pid, data_len, crc_bad);
  modport slave (input hsk_recv, hsk_pid, data_recv, data_pid, data_len, crc_bad);
endinterface

`default_nettype wire
